// ==== design/cs02_pkg.sv ====
package cs02_pkg;

	// ----------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------
	localparam int ADR_W = 24;
	localparam int DAT_W = 12;

	typedef logic [ADR_W-1:0] wb_adr_t;
	typedef logic [DAT_W-1:0] wb_data_t;

	// Master to slaves
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_adr_t  adr;
		wb_data_t dat;
	} wb_req_t;

	// Slave or fabric back to master
	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	// ----------------------------------------------------------
	// Address map
	// ----------------------------------------------------------
	// Scratch RAM at the bottom 1k words
	localparam int RAM_AW = 10;
	localparam logic [ADR_W-RAM_AW-1:0] RAM_BASE_HI = '0;
	// PRNG page E306xx
	localparam logic [15:0] PRNG_PAGE = 16'hE306;
	// Semaphores EFxxxx
	localparam logic [7:0] SEMA_PAGE = 8'hEF;
	localparam int SEMA_N = 16;
	localparam int SEMA_AW = $clog2(SEMA_N);

	// ----------------------------------------------------------
	// PRNG and watchdog
	// ----------------------------------------------------------
	localparam int PRNG_W = 24;
	// x^24+x^23+x^22+x^17+1, right shifting form
	localparam logic [PRNG_W-1:0] PRNG_TAPS = 24'hE1_0000;
	localparam logic [PRNG_W-1:0] PRNG_SEED = 24'h5A_C3E1;
	localparam int ERR_TIMEOUT = 16;
	localparam int ERR_CNT_W = $clog2(ERR_TIMEOUT + 1);

endpackage

// ==== design/cs02_bus_fabric.sv ====
`timescale 1ns/10ps

module cs02_bus_fabric (
	input  logic              cpuclk,
	input  logic              rst,
	input  cs02_pkg::wb_req_t req_i,
	input  cs02_pkg::wb_rsp_t ram_rsp_i,
	input  cs02_pkg::wb_rsp_t prng_rsp_i,
	input  cs02_pkg::wb_rsp_t sema_rsp_i,
	output logic              cs_ram_o,
	output logic              cs_prng_o,
	output logic              cs_sema_o,
	output cs02_pkg::wb_rsp_t rsp_o
);
	import cs02_pkg::*;

	wb_rsp_t merged;
	wb_rsp_t rsp_q;

	// ----------------------------------------------------------
	// Circuit selects
	// ----------------------------------------------------------
	// Pages do not overlap so at most one select is high
	always_comb begin
		cs_ram_o  = req_i.adr[ADR_W-1:RAM_AW] == RAM_BASE_HI;
		cs_prng_o = req_i.adr[ADR_W-1:8] == PRNG_PAGE;
		cs_sema_o = req_i.adr[ADR_W-1:16] == SEMA_PAGE;
	end

	// ----------------------------------------------------------
	// Response merge
	// ----------------------------------------------------------
	// Idle slaves hold dat at zero
	always_comb begin
		merged.ack = ram_rsp_i.ack | prng_rsp_i.ack | sema_rsp_i.ack;
		merged.dat = ram_rsp_i.dat | prng_rsp_i.dat | sema_rsp_i.dat;
	end

	// One register stage toward the master
	always_ff @(posedge cpuclk) begin
		if (rst) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= merged;
		end
	end

	assign rsp_o = rsp_q;

endmodule

// ==== design/cs02_bus_error.sv ====
`timescale 1ns/10ps

module cs02_bus_error (
	input  logic              cpuclk,
	input  logic              rst,
	input  cs02_pkg::wb_req_t req_i,
	input  logic              ack_i,
	output logic              err_o
);
	import cs02_pkg::*;

	logic [ERR_CNT_W-1:0] cnt_q;
	logic                 err_q;

	always_ff @(posedge cpuclk) begin
		if (rst) begin
			cnt_q <= '0;
			err_q <= 1'b0;
		end else if (!req_i.cyc) begin
			// Cycle ended so the error is dropped too
			cnt_q <= '0;
			err_q <= 1'b0;
		end else if (ack_i) begin
			cnt_q <= '0;
		end else if (req_i.stb) begin
			// Saturate and flag on the edge after the limit
			if (cnt_q == ERR_CNT_W'(ERR_TIMEOUT))
				err_q <= 1'b1;
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	assign err_o = err_q;

endmodule

// ==== design/cs02_scratch_ram.sv ====
`timescale 1ns/10ps

module cs02_scratch_ram (
	input  logic              cpuclk,
	input  logic              rst,
	input  logic              cs_i,
	input  cs02_pkg::wb_req_t req_i,
	output cs02_pkg::wb_rsp_t rsp_o
);
	import cs02_pkg::*;

	wb_data_t          mem [0:2**RAM_AW-1];
	logic [RAM_AW-1:0] word_adr;
	logic              strobe;
	logic              go_q;
	logic              done_q;
	logic              ack_q;
	wb_data_t          rd_q;

	assign word_adr = req_i.adr[RAM_AW-1:0];
	assign strobe = cs_i & req_i.cyc & req_i.stb;

	// ----------------------------------------------------------
	// Handshake
	// ----------------------------------------------------------
	// go marks the first sampled strobe, ack follows one edge later
	always_ff @(posedge cpuclk) begin
		if (rst) begin
			go_q   <= 1'b0;
			done_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			go_q  <= strobe & ~go_q & ~done_q;
			ack_q <= go_q;
			// Held until the master lets go of stb
			if (go_q)
				done_q <= 1'b1;
			else if (!req_i.stb)
				done_q <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// Storage
	// ----------------------------------------------------------
	always_ff @(posedge cpuclk) begin
		if (go_q && req_i.we)
			mem[word_adr] <= req_i.dat;
		// Zero outside the ack cycle for the fabric OR
		rd_q <= (go_q && !req_i.we) ? mem[word_adr] : '0;
	end

	assign rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

// ==== design/cs02_prng.sv ====
`timescale 1ns/10ps

module cs02_prng (
	input  logic              cpuclk,
	input  logic              rst,
	input  logic              cs_i,
	input  cs02_pkg::wb_req_t req_i,
	output cs02_pkg::wb_rsp_t rsp_o
);
	import cs02_pkg::*;

	logic [PRNG_W-1:0] lfsr_q;
	logic [PRNG_W-1:0] lfsr_step;
	logic [PRNG_W-1:0] seed_mix;
	logic [1:0]        ofs;
	logic              strobe;
	logic              go_q;
	logic              done_q;
	logic              ack_q;
	wb_data_t          rd_q;

	assign ofs = req_i.adr[1:0];
	assign strobe = cs_i & req_i.cyc & req_i.stb;

	// One Galois step to the right
	assign lfsr_step = {1'b0, lfsr_q[PRNG_W-1:1]} ^ (lfsr_q[0] ? PRNG_TAPS : '0);

	// Offset 2 is the low seed half, offset 3 the high half
	always_comb begin
		if (ofs[0])
			seed_mix = {req_i.dat, lfsr_q[DAT_W-1:0]};
		else
			seed_mix = {lfsr_q[PRNG_W-1:DAT_W], req_i.dat};
		// Stuck state avoided
		if (seed_mix == '0)
			seed_mix = PRNG_SEED;
	end

	// ----------------------------------------------------------
	// Handshake and generator state
	// ----------------------------------------------------------
	always_ff @(posedge cpuclk) begin
		if (rst) begin
			go_q   <= 1'b0;
			done_q <= 1'b0;
			ack_q  <= 1'b0;
			lfsr_q <= PRNG_SEED;
		end else begin
			go_q  <= strobe & ~go_q & ~done_q;
			ack_q <= go_q;
			if (go_q)
				done_q <= 1'b1;
			else if (!req_i.stb)
				done_q <= 1'b0;
			// Seed load
			if (go_q && req_i.we && ofs[1])
				lfsr_q <= seed_mix;
			// Advance after the high half has been read
			else if (go_q && !req_i.we && ofs == 2'd1)
				lfsr_q <= lfsr_step;
		end
	end

	// Read data from the state before any step
	always_ff @(posedge cpuclk) begin
		if (go_q && !req_i.we)
			rd_q <= ofs[0] ? lfsr_q[PRNG_W-1:DAT_W] : lfsr_q[DAT_W-1:0];
		else
			rd_q <= '0;
	end

	assign rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

// ==== design/cs02_sema_mem.sv ====
`timescale 1ns/10ps

module cs02_sema_mem (
	input  logic              cpuclk,
	input  logic              rst,
	input  logic              cs_i,
	input  cs02_pkg::wb_req_t req_i,
	output cs02_pkg::wb_rsp_t rsp_o
);
	import cs02_pkg::*;

	logic [SEMA_N-1:0]  lock_q;
	logic [SEMA_AW-1:0] idx;
	logic               strobe;
	logic               go_q;
	logic               done_q;
	logic               ack_q;
	wb_data_t           rd_q;

	assign idx = req_i.adr[SEMA_AW-1:0];
	assign strobe = cs_i & req_i.cyc & req_i.stb;

	// ----------------------------------------------------------
	// Handshake and lock bits
	// ----------------------------------------------------------
	always_ff @(posedge cpuclk) begin
		if (rst) begin
			go_q   <= 1'b0;
			done_q <= 1'b0;
			ack_q  <= 1'b0;
			lock_q <= '0;
		end else begin
			go_q  <= strobe & ~go_q & ~done_q;
			ack_q <= go_q;
			if (go_q)
				done_q <= 1'b1;
			else if (!req_i.stb)
				done_q <= 1'b0;
			// Read claims, any write releases
			if (go_q)
				lock_q[idx] <= ~req_i.we;
		end
	end

	// 1 means the caller now owns the lock
	always_ff @(posedge cpuclk) begin
		if (go_q && !req_i.we)
			rd_q <= {{(DAT_W-1){1'b0}}, ~lock_q[idx]};
		else
			rd_q <= '0;
	end

	assign rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

// ==== design/cs02_periph_top.sv ====
`timescale 1ns/10ps

module cs02_periph_top (
	input  logic              cpuclk,
	input  logic              rst,
	input  cs02_pkg::wb_req_t req_i,
	output cs02_pkg::wb_rsp_t rsp_o,
	output logic              err_o
);
	import cs02_pkg::*;

	logic    cs_ram;
	logic    cs_prng;
	logic    cs_sema;
	wb_rsp_t ram_rsp;
	wb_rsp_t prng_rsp;
	wb_rsp_t sema_rsp;

	// ----------------------------------------------------------
	// Decode and response merge
	// ----------------------------------------------------------
	cs02_bus_fabric u_fabric (
		.cpuclk     (cpuclk),
		.rst        (rst),
		.req_i      (req_i),
		.ram_rsp_i  (ram_rsp),
		.prng_rsp_i (prng_rsp),
		.sema_rsp_i (sema_rsp),
		.cs_ram_o   (cs_ram),
		.cs_prng_o  (cs_prng),
		.cs_sema_o  (cs_sema),
		.rsp_o      (rsp_o)
	);

	// Watches the registered ack seen by the master
	cs02_bus_error u_bus_error (
		.cpuclk (cpuclk),
		.rst    (rst),
		.req_i  (req_i),
		.ack_i  (rsp_o.ack),
		.err_o  (err_o)
	);

	// ----------------------------------------------------------
	// Slaves
	// ----------------------------------------------------------
	cs02_scratch_ram u_ram (
		.cpuclk (cpuclk),
		.rst    (rst),
		.cs_i   (cs_ram),
		.req_i  (req_i),
		.rsp_o  (ram_rsp)
	);

	cs02_prng u_prng (
		.cpuclk (cpuclk),
		.rst    (rst),
		.cs_i   (cs_prng),
		.req_i  (req_i),
		.rsp_o  (prng_rsp)
	);

	cs02_sema_mem u_sema (
		.cpuclk (cpuclk),
		.rst    (rst),
		.cs_i   (cs_sema),
		.req_i  (req_i),
		.rsp_o  (sema_rsp)
	);

endmodule

// ==== dv/cs02_periph_tb.sv ====
`timescale 1ns/10ps

module cs02_periph_tb;
	import cs02_pkg::*;

	logic    cpuclk;
	logic    rst;
	wb_req_t req;
	wb_rsp_t rsp;
	logic    err;
	int      n_checks;
	int      n_errors;

	cs02_periph_top dut0 (
		.cpuclk (cpuclk),
		.rst    (rst),
		.req_i  (req),
		.rsp_o  (rsp),
		.err_o  (err)
	);

	// 40 ns period, first rising edge at 20 ns
	initial begin
		cpuclk = 1'b0;
		forever begin
			#20 cpuclk = ~cpuclk;
		end
	end

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------
	task automatic check_dat(input wb_data_t got, input wb_data_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t: %0s read data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ack(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t: %0s ack %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t: %0s err %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		n_checks++;
		if (got != exp) begin
			n_errors++;
			$display("[FAIL] %0t: %0s took %0d edges, expected %0d", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------
	// Bus master
	// ----------------------------------------------------------
	// Outputs settle at the edge, inputs change 2 ns later
	task automatic step_clock();
		@(posedge cpuclk);
		#2;
	endtask

	task automatic apply_reset();
		int i;
		rst = 1'b1;
		for (i = 0; i < 4; i++) begin
			step_clock();
			check_ack(rsp.ack, 1'b0, "reset");
			check_err(err, 1'b0, "reset");
		end
		rst = 1'b0;
		step_clock();
		check_ack(rsp.ack, 1'b0, "after reset");
		check_err(err, 1'b0, "after reset");
	endtask

	// One classic cycle, edges counted from the strobe drive
	task automatic run_txn(input string op, input wb_adr_t adr, input wb_data_t dat,
		input string note);
		int   edges;
		logic got_ack;
		logic got_err;
		edges = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = (op == "W");
		req.adr = adr;
		req.dat = (op == "W") ? dat : '0;
		// Bounded wait for ack or err
		while (!got_ack && !got_err && edges < 40) begin
			step_clock();
			edges++;
			got_ack = rsp.ack;
			got_err = err;
		end
		if (!got_ack && !got_err) begin
			n_errors++;
			$display("Timeout: no ack or err within 40 cycles for %0s at %h", note, adr);
		end else if (op == "E") begin
			check_ack(got_ack, 1'b0, note);
			check_err(got_err, 1'b1, note);
			// Counter reaches the limit, err one edge later
			check_latency(edges, ERR_TIMEOUT + 1, note);
		end else begin
			check_ack(got_ack, 1'b1, note);
			check_err(got_err, 1'b0, note);
			// Sampling edge, slave ack, fabric register
			check_latency(edges, 3, note);
			if (op == "R")
				check_dat(rsp.dat, dat, note);
		end
		// stb low for at least one edge so done flags clear
		req = '0;
		step_clock();
		check_err(err, 1'b0, $sformatf("%0s after cyc drop", note));
	endtask

	// ----------------------------------------------------------
	// Golden file replay
	// ----------------------------------------------------------
	initial begin
		int          fd;
		int          code;
		int          c;
		int          gap;
		int          i;
		int unsigned seed;
		string       tok;
		string       note;
		wb_adr_t     adr;
		wb_data_t    dat;
		rst = 1'b1;
		req = '0;
		n_checks = 0;
		n_errors = 0;
		seed = $urandom(32'h0bf7_b180);
		apply_reset();
		fd = $fopen("dv/cs02_periph_golden.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("Could not open dv/cs02_periph_golden.txt for reading");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %s", tok);
				if (code == 1 && tok == "#") begin
					// Rest of a header line
					c = $fgetc(fd);
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end else if (code == 1) begin
					code = $fscanf(fd, " %h %h %s", adr, dat, note);
					if (code != 3 || !(tok == "W" || tok == "R" || tok == "E")) begin
						n_errors++;
						$display("Malformed golden line starting with %0s", tok);
					end else begin
						run_txn(tok, adr, dat, note);
					end
					// Idle gap of 0 to 3 cycles
					gap = $urandom % 4;
					for (i = 0; i < gap; i++)
						step_clock();
				end
			end
			$fclose(fd);
		end
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/cs02_periph_golden.txt ====
# op addr data note : W writes data, R reads and expects data, E is unmapped and expects err
# addr and data in hex, note is one word
R E30600 3E1 prng_reset_lo
R E30601 5AC prng_reset_hi
R E30600 1F0 prng_step1_lo
R E30601 CC6 prng_step1_hi
R E30600 0F8 prng_step2_lo
R E30601 663 prng_step2_hi
W E30602 123 prng_seed_lo_wr
W E30603 456 prng_seed_hi_wr
R E30600 123 prng_newseed_lo
R E30601 456 prng_newseed_hi
R E30600 091 prng_newstep1_lo
R E30601 C3B prng_newstep1_hi
W E30602 000 prng_zero_lo_wr
W E30603 000 prng_zero_hi_wr
R E30600 3E1 prng_zero_seed_lo
R E30601 5AC prng_zero_seed_hi
R E30600 1F0 prng_zero_step1_lo
R E30601 CC6 prng_zero_step1_hi
W 000000 A5C ram_wr_0
W 000001 3F0 ram_wr_1
W 0003FF FFF ram_wr_top
W 000200 123 ram_wr_mid
R 000001 3F0 ram_rd_1
R 000000 A5C ram_rd_0
R 0003FF FFF ram_rd_top
R 000200 123 ram_rd_mid
W 000001 00E ram_rewrite_1
R 000001 00E ram_rd_rewrite_1
R EF0003 001 sema3_claim
R EF0003 000 sema3_taken
R EF0005 001 sema5_claim
W EF0003 ABC sema3_release
R EF0003 001 sema3_reclaim
R EF0005 000 sema5_still_taken
E 800000 000 unmapped_access
R 000000 A5C ram_after_err

// ==== cs02_periph_top.f ====
design/cs02_pkg.sv
design/cs02_bus_fabric.sv
design/cs02_bus_error.sv
design/cs02_scratch_ram.sv
design/cs02_prng.sv
design/cs02_sema_mem.sv
design/cs02_periph_top.sv
dv/cs02_periph_tb.sv

// ==== Bender.yml ====
package:
  name: cs02_periph

sources:
  - files:
      - design/cs02_pkg.sv
      - design/cs02_bus_fabric.sv
      - design/cs02_bus_error.sv
      - design/cs02_scratch_ram.sv
      - design/cs02_prng.sv
      - design/cs02_sema_mem.sv
      - design/cs02_periph_top.sv
  - target: test
    files:
      - dv/cs02_periph_tb.sv
